//--- include/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// data widths
`define CONV_PIXEL_W   8
`define CONV_OUT_W     16
`define CONV_ACC_W     20

// image side range and index widths
`define CONV_IMG_MAX   8
`define CONV_IMG_MIN   3
`define CONV_SIZE_W    4
`define CONV_COORD_W   3

// kernel and activation
`define CONV_TAPS      9
`define CONV_LEAKY_DIV 10

`endif

//--- verilog/conv_pkg.sv
`include "conv_cfg.svh"

package conv_pkg;

	// --------------------------------------------------
	// control encodings
	// --------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		LOAD_KERNEL,
		LOAD_IMAGE,
		SWEEP,
		DRAIN
	} conv_state_e;

	typedef enum logic {
		PAD_ZERO,
		PAD_REPLICATE
	} pad_mode_e;

	typedef enum logic {
		ACT_RELU,
		ACT_LEAKY
	} act_mode_e;

	// --------------------------------------------------
	// data types
	// --------------------------------------------------
	typedef logic signed [`CONV_PIXEL_W-1:0]   pixel_t;
	typedef logic signed [2*`CONV_PIXEL_W-1:0] product_t;
	typedef logic signed [`CONV_ACC_W-1:0]     acc_t;
	typedef logic signed [`CONV_OUT_W-1:0]     result_t;
	typedef logic [`CONV_COORD_W-1:0]          coord_t;

endpackage

//--- verilog/conv_fsm.sv
`timescale 1ns/1ps

module conv_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  kernel_valid,
	input  logic                  image_valid,
	input  logic                  last,
	input  logic                  empty,
	output conv_pkg::conv_state_e state
);

	conv_pkg::conv_state_e next_state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= conv_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// --------------------------------------------------
	// transitions
	// --------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			conv_pkg::IDLE: begin
				// first beat of either stream is taken here
				if (kernel_valid) begin
					next_state = conv_pkg::LOAD_KERNEL;
				end else if (image_valid) begin
					next_state = conv_pkg::LOAD_IMAGE;
				end
			end
			conv_pkg::LOAD_KERNEL: begin
				if (!kernel_valid) begin
					next_state = conv_pkg::IDLE;
				end
			end
			conv_pkg::LOAD_IMAGE: begin
				if (image_valid && last) begin
					next_state = conv_pkg::SWEEP;
				end
			end
			conv_pkg::SWEEP: begin
				// final position goes into the pipe this cycle
				if (last) begin
					next_state = conv_pkg::DRAIN;
				end
			end
			conv_pkg::DRAIN: begin
				if (empty) begin
					next_state = conv_pkg::IDLE;
				end
			end
			default: begin
				next_state = conv_pkg::IDLE;
			end
		endcase
	end

endmodule

//--- verilog/pixel_counter.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module pixel_counter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  conv_pkg::conv_state_e   state,
	input  logic                    image_valid,
	input  logic [`CONV_SIZE_W-1:0] img_size,
	output conv_pkg::coord_t        row,
	output conv_pkg::coord_t        col,
	output logic                    last
);

	conv_pkg::coord_t max_idx;
	logic             load_beat;
	logic             step;

	assign max_idx = conv_pkg::coord_t'(img_size - 1'b1);
	assign last    = (row == max_idx) && (col == max_idx);

	// the first image beat arrives while still idle
	assign load_beat = image_valid &&
		(state == conv_pkg::IDLE || state == conv_pkg::LOAD_IMAGE);
	assign step = load_beat || (state == conv_pkg::SWEEP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= '0;
			col <= '0;
		end else if (step) begin
			if (last) begin
				// wrap to origin, which also starts the sweep
				row <= '0;
				col <= '0;
			end else if (col == max_idx) begin
				row <= row + 1'b1;
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end else if (state == conv_pkg::IDLE) begin
			row <= '0;
			col <= '0;
		end
	end

endmodule

//--- verilog/kernel_regs.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module kernel_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  conv_pkg::conv_state_e   state,
	input  logic                    kernel_valid,
	input  logic [`CONV_SIZE_W-1:0] image_size,
	input  logic                    pad_mode,
	input  logic                    act_mode,
	input  conv_pkg::pixel_t        in_data,
	output conv_pkg::pixel_t        taps [`CONV_TAPS],
	output logic [`CONV_SIZE_W-1:0] img_size,
	output conv_pkg::pad_mode_e     pad_sel,
	output conv_pkg::act_mode_e     act_sel
);

	// tap chain, oldest beat ends up in taps[0] (top left)
	always_ff @(posedge clk) begin
		if (kernel_valid) begin
			for (int i = 0; i < `CONV_TAPS - 1; i++) begin
				taps[i] <= taps[i+1];
			end
			taps[`CONV_TAPS-1] <= in_data;
		end
	end

	// job settings, sampled on the opening kernel beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			img_size <= `CONV_SIZE_W'(`CONV_IMG_MIN);
			pad_sel  <= conv_pkg::PAD_ZERO;
			act_sel  <= conv_pkg::ACT_RELU;
		end else if (kernel_valid && state == conv_pkg::IDLE) begin
			img_size <= image_size;
			pad_sel  <= conv_pkg::pad_mode_e'(pad_mode);
			act_sel  <= conv_pkg::act_mode_e'(act_mode);
		end
	end

endmodule

//--- verilog/image_buffer.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module image_buffer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  conv_pkg::conv_state_e   state,
	input  logic                    image_valid,
	input  conv_pkg::pixel_t        in_data,
	input  conv_pkg::coord_t        row,
	input  conv_pkg::coord_t        col,
	input  logic [`CONV_SIZE_W-1:0] img_size,
	input  conv_pkg::pad_mode_e     pad_sel,
	output conv_pkg::pixel_t        window [`CONV_TAPS]
);

	conv_pkg::pixel_t store [`CONV_IMG_MAX][`CONV_IMG_MAX];
	logic             wr_en;

	assign wr_en = image_valid &&
		(state == conv_pkg::IDLE || state == conv_pkg::LOAD_IMAGE);

	// --------------------------------------------------
	// pixel store
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `CONV_IMG_MAX; r++) begin
				for (int c = 0; c < `CONV_IMG_MAX; c++) begin
					store[r][c] <= '0;
				end
			end
		end else if (wr_en) begin
			store[row][col] <= in_data;
		end
	end

	// --------------------------------------------------
	// padded 3x3 window around (row, col)
	// --------------------------------------------------
	always_comb begin
		int               r;
		int               c;
		int               lim;
		logic             in_range;
		conv_pkg::coord_t rs;
		conv_pkg::coord_t cs;

		lim = int'(img_size) - 1;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				r = int'(row) + i - 1;
				c = int'(col) + j - 1;
				in_range = (r >= 0) && (r <= lim) && (c >= 0) && (c <= lim);
				// clamp into the image; only used as-is when replicating
				if (r < 0) r = 0;
				else if (r > lim) r = lim;
				if (c < 0) c = 0;
				else if (c > lim) c = lim;
				rs = conv_pkg::coord_t'(r);
				cs = conv_pkg::coord_t'(c);
				if (in_range || pad_sel == conv_pkg::PAD_REPLICATE) begin
					window[i*3+j] = store[rs][cs];
				end else begin
					window[i*3+j] = '0;
				end
			end
		end
	end

endmodule

//--- verilog/conv_datapath.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_datapath (
	input  logic                  clk,
	input  logic                  rst_n,
	input  conv_pkg::conv_state_e state,
	input  conv_pkg::pixel_t      window [`CONV_TAPS],
	input  conv_pkg::pixel_t      taps [`CONV_TAPS],
	input  conv_pkg::act_mode_e   act_sel,
	output logic                  out_valid,
	output conv_pkg::result_t     out_data,
	output logic                  empty
);

	localparam conv_pkg::acc_t SAT_MAX =
		conv_pkg::acc_t'((1 << (`CONV_OUT_W - 1)) - 1);

	conv_pkg::product_t prod [`CONV_TAPS];
	logic               prod_valid;
	conv_pkg::acc_t     sum;
	conv_pkg::result_t  act_out;

	// --------------------------------------------------
	// stage 1: products
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CONV_TAPS; i++) begin
			prod[i] <= window[i] * taps[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= (state == conv_pkg::SWEEP);
		end
	end

	// --------------------------------------------------
	// stage 2: sum, activation, cap
	// --------------------------------------------------
	always_comb begin
		sum = '0;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			sum = sum + conv_pkg::acc_t'(prod[i]);
		end
		if (!sum[`CONV_ACC_W-1]) begin
			act_out = (sum > SAT_MAX) ? conv_pkg::result_t'(SAT_MAX) : conv_pkg::result_t'(sum);
		end else if (act_sel == conv_pkg::ACT_LEAKY) begin
			// signed divide truncates toward zero, always in range
			act_out = conv_pkg::result_t'(sum / `CONV_LEAKY_DIV);
		end else begin
			act_out = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else begin
			out_valid <= prod_valid;
			out_data  <= prod_valid ? act_out : '0;
		end
	end

	assign empty = !prod_valid && !out_valid;

endmodule

//--- verilog/conv_top.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           kernel_valid,
	input  logic                           image_valid,
	input  logic [`CONV_SIZE_W-1:0]        image_size,
	input  logic                           pad_mode,
	input  logic                           act_mode,
	input  logic signed [`CONV_PIXEL_W-1:0] in_data,
	output logic                           out_valid,
	output logic signed [`CONV_OUT_W-1:0]   out_data
);

	conv_pkg::conv_state_e   state;
	conv_pkg::coord_t        row;
	conv_pkg::coord_t        col;
	logic                    last;
	logic                    empty;
	conv_pkg::pixel_t        taps [`CONV_TAPS];
	conv_pkg::pixel_t        window [`CONV_TAPS];
	logic [`CONV_SIZE_W-1:0] img_size;
	conv_pkg::pad_mode_e     pad_sel;
	conv_pkg::act_mode_e     act_sel;

	conv_fsm i_conv_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.kernel_valid (kernel_valid),
		.image_valid  (image_valid),
		.last         (last),
		.empty        (empty),
		.state        (state)
	);

	pixel_counter i_pixel_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (state),
		.image_valid (image_valid),
		.img_size    (img_size),
		.row         (row),
		.col         (col),
		.last        (last)
	);

	kernel_regs i_kernel_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.state        (state),
		.kernel_valid (kernel_valid),
		.image_size   (image_size),
		.pad_mode     (pad_mode),
		.act_mode     (act_mode),
		.in_data      (in_data),
		.taps         (taps),
		.img_size     (img_size),
		.pad_sel      (pad_sel),
		.act_sel      (act_sel)
	);

	image_buffer i_image_buffer (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (state),
		.image_valid (image_valid),
		.in_data     (in_data),
		.row         (row),
		.col         (col),
		.img_size    (img_size),
		.pad_sel     (pad_sel),
		.window      (window)
	);

	conv_datapath i_conv_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.state     (state),
		.window    (window),
		.taps      (taps),
		.act_sel   (act_sel),
		.out_valid (out_valid),
		.out_data  (out_data),
		.empty     (empty)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset low for the first 16 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- dv/conv_properties.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_properties (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    kernel_valid,
	input logic                    image_valid,
	input logic                    out_valid,
	input logic [`CONV_OUT_W-1:0]  out_data,
	input conv_pkg::conv_state_e   state
);

	// --------------------------------------------------
	// output stream
	// --------------------------------------------------
	out_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0)
		else $error("out_data is nonzero while out_valid is low");

	// results only while sweeping or draining
	out_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (state == conv_pkg::SWEEP || state == conv_pkg::DRAIN))
		else $error("out_valid is high outside SWEEP and DRAIN");

	// --------------------------------------------------
	// input streams
	// --------------------------------------------------
	streams_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(kernel_valid && image_valid))
		else $error("kernel_valid and image_valid are high together");

endmodule

bind conv_top conv_properties i_conv_properties (
	.clk          (clk),
	.rst_n        (rst_n),
	.kernel_valid (kernel_valid),
	.image_valid  (image_valid),
	.out_valid    (out_valid),
	.out_data     (out_data),
	.state        (state)
);

//--- dv/conv_tb.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_tb;

	localparam int NUM_JOBS = 12;
	localparam int MARGIN   = 200;
	localparam int OUT_MAX  = (1 << (`CONV_OUT_W - 1)) - 1;

	logic                            clk;
	logic                            rst_n;
	logic                            kernel_valid;
	logic                            image_valid;
	logic [`CONV_SIZE_W-1:0]         image_size;
	logic                            pad_mode;
	logic                            act_mode;
	logic signed [`CONV_PIXEL_W-1:0] in_data;
	logic                            out_valid;
	logic signed [`CONV_OUT_W-1:0]   out_data;

	// job table: side, pad (1 = replicate), act (1 = leaky), data kind
	// kind 0 random, 1 mostly negative taps, 2 everything at 127
	int job_size [NUM_JOBS] = '{4, 6, 3, 8, 5, 7, 4, 3, 8, 3, 6, 5};
	int job_pad  [NUM_JOBS] = '{0, 0, 1, 1, 0, 1, 0, 1, 1, 0, 1, 0};
	int job_act  [NUM_JOBS] = '{0, 0, 0, 0, 1, 1, 0, 0, 1, 0, 1, 0};
	int job_kind [NUM_JOBS] = '{0, 0, 0, 0, 1, 1, 2, 2, 0, 0, 0, 0};

	logic [15:0]                     lfsr;
	logic signed [`CONV_PIXEL_W-1:0] ker [`CONV_TAPS];
	logic signed [`CONV_PIXEL_W-1:0] img [`CONV_IMG_MAX][`CONV_IMG_MAX];
	logic signed [`CONV_OUT_W-1:0]   exp_q [$];
	logic signed [`CONV_OUT_W-1:0]   exp_val;
	int cur_size;
	int cur_pad;
	int cur_act;
	int job_got = 0;
	int since_img = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int cycle;
	int limit;

	tb_clock i_tb_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	conv_top i_conv_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.kernel_valid (kernel_valid),
		.image_valid  (image_valid),
		.image_size   (image_size),
		.pad_mode     (pad_mode),
		.act_mode     (act_mode),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	// --------------------------------------------------
	// random source and reference model
	// --------------------------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// padded image read
	function automatic int pixel_at(input int r, input int c);
		int rr;
		int cc;
		if (r < 0 || c < 0 || r >= cur_size || c >= cur_size) begin
			if (cur_pad == 0) begin
				return 0;
			end
		end
		rr = (r < 0) ? 0 : ((r >= cur_size) ? cur_size - 1 : r);
		cc = (c < 0) ? 0 : ((c >= cur_size) ? cur_size - 1 : c);
		return int'(img[rr][cc]);
	endfunction

	function automatic logic signed [`CONV_OUT_W-1:0] expected_at(input int r, input int c);
		int sum;
		int res;
		sum = 0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				sum += pixel_at(r + i - 1, c + j - 1) * int'(ker[i*3+j]);
			end
		end
		if (sum >= 0) begin
			res = (sum > OUT_MAX) ? OUT_MAX : sum;
		end else if (cur_act == 1) begin
			// truncates toward zero
			res = sum / `CONV_LEAKY_DIV;
		end else begin
			res = 0;
		end
		return `CONV_OUT_W'(res);
	endfunction

	function automatic int job_cycles(input int n);
		return 20 + 2 * n * n;
	endfunction

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic fill_job(input int kind);
		logic [15:0] v;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			if (kind == 2) begin
				ker[i] = 8'sd127;
			end else begin
				draw_bits(8, v);
				ker[i] = v[7:0];
				if (kind == 1 && ker[i] > 0) begin
					draw_bits(2, v);
					if (v[1:0] != 2'b00) begin
						ker[i] = -ker[i];
					end
				end
			end
		end
		for (int r = 0; r < cur_size; r++) begin
			for (int c = 0; c < cur_size; c++) begin
				if (kind == 2) begin
					img[r][c] = 8'sd127;
				end else if (kind == 1) begin
					draw_bits(7, v);
					img[r][c] = {1'b0, v[6:0]};
				end else begin
					draw_bits(8, v);
					img[r][c] = v[7:0];
				end
			end
		end
	endtask

	task automatic play_job(input int idx);
		int n;
		int waited;
		n = job_size[idx];
		cur_size = n;
		cur_pad = job_pad[idx];
		cur_act = job_act[idx];
		fill_job(job_kind[idx]);
		job_got = 0;
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				exp_q.push_back(expected_at(r, c));
			end
		end
		// kernel taps in raster order, settings held for the whole job
		for (int i = 0; i < `CONV_TAPS; i++) begin
			@(posedge clk);
			kernel_valid <= 1'b1;
			in_data      <= ker[i];
			image_size   <= `CONV_SIZE_W'(n);
			pad_mode     <= 1'(cur_pad);
			act_mode     <= 1'(cur_act);
		end
		@(posedge clk);
		kernel_valid <= 1'b0;
		in_data      <= '0;
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				@(posedge clk);
				image_valid <= 1'b1;
				in_data     <= img[r][c];
			end
		end
		@(posedge clk);
		image_valid <= 1'b0;
		in_data     <= '0;
		// every result is due within size squared plus a few cycles
		waited = 0;
		while (job_got < n * n && waited < n * n + 8) begin
			@(posedge clk);
			waited++;
		end
		// let the FSM drain back to IDLE
		repeat (4) @(posedge clk);
		if (job_got != n * n) begin
			$display("job %0d produced %0d results instead of %0d", idx, job_got, n * n);
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic run_test(input string name, input int first, input int count);
		int err_before;
		err_before = errors;
		for (int k = first; k < first + count; k++) begin
			play_job(k);
		end
		report_test(name, err_before);
	endtask

	// --------------------------------------------------
	// output monitor
	// --------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (image_valid) begin
				since_img = 0;
			end else begin
				since_img = since_img + 1;
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("unexpected result at %0t with nothing pending", $time);
					errors++;
				end else begin
					exp_val = exp_q.pop_front();
					checks++;
					// first result three edges after the last image beat is driven
					if (job_got == 0 && since_img != 3) begin
						$display("first result came %0d cycles after the image, not 3", since_img);
						errors++;
					end
					if (out_data !== exp_val) begin
						$display("[ERROR] %0t: result %0d expected %0d, got %0d",
							$time, job_got, exp_val, out_data);
						errors++;
					end
					job_got++;
				end
			end else if (out_data !== '0) begin
				$display("[ERROR] %0t: out_data expected 0 while idle, got %0d", $time, out_data);
				errors++;
			end
		end
	end

	// watchdog
	initial begin
		limit = 16 + 20 + MARGIN;
		for (int k = 0; k < NUM_JOBS; k++) begin
			limit += job_cycles(job_size[k]);
		end
		cycle = 0;
		while (cycle < limit) begin
			@(posedge clk);
			cycle++;
		end
		$display("run stopped after %0d cycles, results did not all arrive", cycle);
		$display("sim failed");
		$finish;
	end

	initial begin
		int err_before;
		kernel_valid = 1'b0;
		image_valid  = 1'b0;
		image_size   = `CONV_SIZE_W'(`CONV_IMG_MIN);
		pad_mode     = 1'b0;
		act_mode     = 1'b0;
		in_data      = '0;
		lfsr         = 16'd97;
		wait (rst_n === 1'b1);
		@(posedge clk);
		err_before = errors;
		repeat (20) @(posedge clk);
		report_test("reset_idle", err_before);
		run_test("zero_pad_relu", 0, 2);
		run_test("replicate_extremes", 2, 2);
		run_test("leaky_negative", 4, 2);
		run_test("saturation", 6, 2);
		run_test("back_to_back", 8, 4);
		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+include
verilog/conv_pkg.sv
verilog/conv_fsm.sv
verilog/pixel_counter.sv
verilog/kernel_regs.sv
verilog/image_buffer.sv
verilog/conv_datapath.sv
verilog/conv_top.sv
dv/tb_clock.sv
dv/conv_properties.sv
dv/conv_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f project.f -o conv_sim \
	&& ./obj_dir/conv_sim | tee /dev/stderr | grep -qx "sim passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
